//--- seibu_sound_pkg.sv
// ----------------------------------------
// seibu sound bus package
// bus types, z80 memory map, open bus value
// ----------------------------------------
package seibu_sound_pkg;

    // z80 bus widths
    typedef logic [15:0] z80_addr_t;
    typedef logic [7:0]  z80_data_t;

    // bank rom address is bank bit on top of z80 a14..a0
    typedef logic [15:0] bank_rom_addr_t;

    // two coin switches
    typedef logic [1:0]  coin_t;

    // memory ranges, end addresses are exclusive
    localparam z80_addr_t rom_end_addr     = 16'h2000;
    localparam z80_addr_t ram_end_addr     = 16'h2800;

    // write-only control registers
    localparam z80_addr_t pending_clr_addr = 16'h4000;
    localparam z80_addr_t irq_clr_addr     = 16'h4001;
    localparam z80_addr_t bank_addr        = 16'h4007;

    // ym3812 address and data ports
    localparam z80_addr_t ym_addr0         = 16'h4008;
    localparam z80_addr_t ym_addr1         = 16'h4009;

    // read side of the mailbox and the coin port
    localparam z80_addr_t latch0_addr      = 16'h4010;
    localparam z80_addr_t latch1_addr      = 16'h4011;
    localparam z80_addr_t pending_addr     = 16'h4012;
    localparam z80_addr_t coin_addr        = 16'h4013;

    // replies back to the 68k
    localparam z80_addr_t reply0_addr      = 16'h4018;
    localparam z80_addr_t reply1_addr      = 16'h4019;

    // oki6295 and the banked rom window
    localparam z80_addr_t oki_addr         = 16'h6000;
    localparam z80_addr_t bank_rom_start   = 16'h8000;

    // value seen by the z80 when nothing drives the bus
    localparam z80_data_t open_bus_data    = 8'hff;

endpackage

//--- z80_cs.sv
// ----------------------------------------
// z80 address decoder
// chip selects and register write strobes
// ----------------------------------------
`timescale 1ns/1ps

module z80_cs (
    input  seibu_sound_pkg::z80_addr_t z80_addr,
    input  logic                       z80_wr_n,
    input  logic                       z80_rd_n,

    output logic                       z80_rom_cs,
    output logic                       bank_rom_cs,
    output logic                       z80_ram_cs,
    output logic                       ym_cs_0,
    output logic                       ym_cs_1,
    output logic                       m68k_latch0_cs,
    output logic                       m68k_latch1_cs,
    output logic                       main_data_pending_cs,
    output logic                       read_coin_cs,
    output logic                       ym_wr,
    output logic                       oki_wr,
    output logic                       oki_rd,

    output logic                       pending_clr_we,
    output logic                       irq_clr_we,
    output logic                       bank_we,
    output logic                       reply0_we,
    output logic                       reply1_we
);

    // write cycle on the z80 bus
    logic wr;

    assign wr = ~z80_wr_n;

    always_comb begin
        // memory ranges
        z80_rom_cs  = (z80_addr < seibu_sound_pkg::rom_end_addr);
        z80_ram_cs  = (z80_addr >= seibu_sound_pkg::rom_end_addr) &&
                      (z80_addr <  seibu_sound_pkg::ram_end_addr);
        // upper 32k is the banked window
        bank_rom_cs = (z80_addr >= seibu_sound_pkg::bank_rom_start);

        // ym3812 ports, a0 picks address or data
        ym_cs_0 = (z80_addr == seibu_sound_pkg::ym_addr0);
        ym_cs_1 = (z80_addr == seibu_sound_pkg::ym_addr1);
        ym_wr   = (ym_cs_0 || ym_cs_1) && wr;

        // read-only i/o, the read mux gates these by itself
        m68k_latch0_cs       = (z80_addr == seibu_sound_pkg::latch0_addr);
        m68k_latch1_cs       = (z80_addr == seibu_sound_pkg::latch1_addr);
        main_data_pending_cs = (z80_addr == seibu_sound_pkg::pending_addr);
        read_coin_cs         = (z80_addr == seibu_sound_pkg::coin_addr);

        // oki is the only chip that needs separate rd and wr
        oki_rd = (z80_addr == seibu_sound_pkg::oki_addr) && !z80_rd_n;
        oki_wr = (z80_addr == seibu_sound_pkg::oki_addr) && wr;

        // strobes into the register block
        pending_clr_we = (z80_addr == seibu_sound_pkg::pending_clr_addr) && wr;
        irq_clr_we     = (z80_addr == seibu_sound_pkg::irq_clr_addr) && wr;
        bank_we        = (z80_addr == seibu_sound_pkg::bank_addr) && wr;
        reply0_we      = (z80_addr == seibu_sound_pkg::reply0_addr) && wr;
        reply1_we      = (z80_addr == seibu_sound_pkg::reply1_addr) && wr;
    end

endmodule

//--- sound_regs.sv
// ----------------------------------------
// sound cpu registers
// 68k/z80 mailbox, flags, rom bank, coin
// ----------------------------------------
`timescale 1ns/1ps

module sound_regs (
    input  logic                       clk,
    input  logic                       rst,

    // z80 write data and decoded strobes
    input  seibu_sound_pkg::z80_data_t z80_dout,
    input  logic                       pending_clr_we,
    input  logic                       irq_clr_we,
    input  logic                       bank_we,
    input  logic                       reply0_we,
    input  logic                       reply1_we,

    // 68k command side
    input  logic                       m68k_wr,
    input  logic                       m68k_sel,
    input  seibu_sound_pkg::z80_data_t m68k_din,

    input  seibu_sound_pkg::coin_t     coin,

    output seibu_sound_pkg::z80_data_t latch0,
    output seibu_sound_pkg::z80_data_t latch1,
    output seibu_sound_pkg::z80_data_t reply0,
    output seibu_sound_pkg::z80_data_t reply1,
    output logic                       pending,
    output logic                       z80_irq,
    output logic                       bank,
    output seibu_sound_pkg::coin_t     coin_q
);

    // 68k write decoded per latch
    logic wr_latch0;
    logic wr_latch1;

    assign wr_latch0 = m68k_wr && !m68k_sel;
    assign wr_latch1 = m68k_wr &&  m68k_sel;

    // command latches, loaded by the 68k
    always_ff @(posedge clk) begin
        if (rst) begin
            latch0 <= '0;
            latch1 <= '0;
        end else begin
            if (wr_latch0) begin
                latch0 <= m68k_din;
            end
            if (wr_latch1) begin
                latch1 <= m68k_din;
            end
        end
    end

    // reply latches, loaded by the z80
    always_ff @(posedge clk) begin
        if (rst) begin
            reply0 <= '0;
            reply1 <= '0;
        end else begin
            if (reply0_we) begin
                reply0 <= z80_dout;
            end
            if (reply1_we) begin
                reply1 <= z80_dout;
            end
        end
    end

    // pending and irq both raised by any 68k command
    // a set on the same edge as a clear wins
    always_ff @(posedge clk) begin
        if (rst) begin
            pending <= 1'b0;
            z80_irq <= 1'b0;
        end else begin
            if (m68k_wr) begin
                pending <= 1'b1;
            end else if (pending_clr_we) begin
                pending <= 1'b0;
            end

            // irq clear is its own address, independent of pending
            if (m68k_wr) begin
                z80_irq <= 1'b1;
            end else if (irq_clr_we) begin
                z80_irq <= 1'b0;
            end
        end
    end

    // rom bank select, only d0 is wired on the board
    always_ff @(posedge clk) begin
        if (rst) begin
            bank <= 1'b0;
        end else if (bank_we) begin
            bank <= z80_dout[0];
        end
    end

    // coin switches sampled every clock
    always_ff @(posedge clk) begin
        if (rst) begin
            coin_q <= '0;
        end else begin
            coin_q <= coin;
        end
    end

endmodule

//--- z80_rd_mux.sv
// ----------------------------------------
// z80 read data multiplexer
// ----------------------------------------
`timescale 1ns/1ps

module z80_rd_mux (
    // read selects from the decoder
    input  logic                       z80_rom_cs,
    input  logic                       bank_rom_cs,
    input  logic                       z80_ram_cs,
    input  logic                       ym_cs_0,
    input  logic                       m68k_latch0_cs,
    input  logic                       m68k_latch1_cs,
    input  logic                       main_data_pending_cs,
    input  logic                       read_coin_cs,
    input  logic                       oki_rd,

    // data sources
    input  seibu_sound_pkg::z80_data_t rom_data,
    input  seibu_sound_pkg::z80_data_t ram_data,
    input  seibu_sound_pkg::z80_data_t ym_dout,
    input  seibu_sound_pkg::z80_data_t oki_dout,
    input  seibu_sound_pkg::z80_data_t latch0,
    input  seibu_sound_pkg::z80_data_t latch1,
    input  logic                       pending,
    input  seibu_sound_pkg::coin_t     coin_q,

    output seibu_sound_pkg::z80_data_t z80_din
);

    // the selects are mutually exclusive, order does not matter
    always_comb begin
        if (z80_rom_cs || bank_rom_cs) begin
            // fixed and banked rom share the external rom data bus
            z80_din = rom_data;
        end else if (z80_ram_cs) begin
            z80_din = ram_data;
        end else if (ym_cs_0) begin
            z80_din = ym_dout;
        end else if (m68k_latch0_cs) begin
            z80_din = latch0;
        end else if (m68k_latch1_cs) begin
            z80_din = latch1;
        end else if (main_data_pending_cs) begin
            z80_din = {7'b0, pending};
        end else if (read_coin_cs) begin
            z80_din = {6'b0, coin_q};
        end else if (oki_rd) begin
            z80_din = oki_dout;
        end else begin
            // ym port 1 and unmapped space float high
            z80_din = seibu_sound_pkg::open_bus_data;
        end
    end

endmodule

//--- seibu_sound_bus.sv
// ----------------------------------------
// seibu sound cpu bus logic, top level
// decoder, registers and z80 read mux
// ----------------------------------------
`timescale 1ns/1ps

module seibu_sound_bus (
    input  logic                            clk,
    input  logic                            rst,

    // z80 bus
    input  seibu_sound_pkg::z80_addr_t      z80_addr,
    input  logic                            z80_rd_n,
    input  logic                            z80_wr_n,
    input  seibu_sound_pkg::z80_data_t      z80_dout,
    output seibu_sound_pkg::z80_data_t      z80_din,

    // 68k side of the mailbox
    input  logic                            m68k_wr,
    input  logic                            m68k_sel,
    input  seibu_sound_pkg::z80_data_t      m68k_din,
    output seibu_sound_pkg::z80_data_t      reply0,
    output seibu_sound_pkg::z80_data_t      reply1,
    output logic                            z80_irq,

    input  seibu_sound_pkg::coin_t          coin,

    // external memories and sound chips
    input  seibu_sound_pkg::z80_data_t      rom_data,
    input  seibu_sound_pkg::z80_data_t      ram_data,
    input  seibu_sound_pkg::z80_data_t      ym_dout,
    input  seibu_sound_pkg::z80_data_t      oki_dout,
    output logic                            z80_rom_cs,
    output logic                            bank_rom_cs,
    output seibu_sound_pkg::bank_rom_addr_t bank_rom_addr,
    output logic                            z80_ram_cs,
    output logic                            ym_cs_0,
    output logic                            ym_cs_1,
    output logic                            ym_wr,
    output logic                            oki_wr,
    output logic                            oki_rd
);

    // decoder to register block and read mux
    logic m68k_latch0_cs;
    logic m68k_latch1_cs;
    logic main_data_pending_cs;
    logic read_coin_cs;
    logic pending_clr_we;
    logic irq_clr_we;
    logic bank_we;
    logic reply0_we;
    logic reply1_we;

    // register state seen by the z80
    seibu_sound_pkg::z80_data_t latch0;
    seibu_sound_pkg::z80_data_t latch1;
    logic                       pending;
    logic                       bank;
    seibu_sound_pkg::coin_t     coin_q;

    // bank bit replaces a15 of the z80 address
    assign bank_rom_addr = {bank, z80_addr[14:0]};

    z80_cs i_z80_cs (
        .z80_addr             (z80_addr),
        .z80_wr_n             (z80_wr_n),
        .z80_rd_n             (z80_rd_n),
        .z80_rom_cs           (z80_rom_cs),
        .bank_rom_cs          (bank_rom_cs),
        .z80_ram_cs           (z80_ram_cs),
        .ym_cs_0              (ym_cs_0),
        .ym_cs_1              (ym_cs_1),
        .m68k_latch0_cs       (m68k_latch0_cs),
        .m68k_latch1_cs       (m68k_latch1_cs),
        .main_data_pending_cs (main_data_pending_cs),
        .read_coin_cs         (read_coin_cs),
        .ym_wr                (ym_wr),
        .oki_wr               (oki_wr),
        .oki_rd               (oki_rd),
        .pending_clr_we       (pending_clr_we),
        .irq_clr_we           (irq_clr_we),
        .bank_we              (bank_we),
        .reply0_we            (reply0_we),
        .reply1_we            (reply1_we)
    );

    sound_regs i_sound_regs (
        .clk            (clk),
        .rst            (rst),
        .z80_dout       (z80_dout),
        .pending_clr_we (pending_clr_we),
        .irq_clr_we     (irq_clr_we),
        .bank_we        (bank_we),
        .reply0_we      (reply0_we),
        .reply1_we      (reply1_we),
        .m68k_wr        (m68k_wr),
        .m68k_sel       (m68k_sel),
        .m68k_din       (m68k_din),
        .coin           (coin),
        .latch0         (latch0),
        .latch1         (latch1),
        .reply0         (reply0),
        .reply1         (reply1),
        .pending        (pending),
        .z80_irq        (z80_irq),
        .bank           (bank),
        .coin_q         (coin_q)
    );

    z80_rd_mux i_z80_rd_mux (
        .z80_rom_cs           (z80_rom_cs),
        .bank_rom_cs          (bank_rom_cs),
        .z80_ram_cs           (z80_ram_cs),
        .ym_cs_0              (ym_cs_0),
        .m68k_latch0_cs       (m68k_latch0_cs),
        .m68k_latch1_cs       (m68k_latch1_cs),
        .main_data_pending_cs (main_data_pending_cs),
        .read_coin_cs         (read_coin_cs),
        .oki_rd               (oki_rd),
        .rom_data             (rom_data),
        .ram_data             (ram_data),
        .ym_dout              (ym_dout),
        .oki_dout             (oki_dout),
        .latch0               (latch0),
        .latch1               (latch1),
        .pending              (pending),
        .coin_q               (coin_q),
        .z80_din              (z80_din)
    );

endmodule

//--- sound_bus_checker.sv
// ----------------------------------------
// sound bus checker
// register reference model, compares every dut port on each clock
// ----------------------------------------
`timescale 1ns/1ps

module sound_bus_checker (
    input  logic                            clk,
    input  logic                            rst,
    input  logic [2:0]                      test_id,

    // dut inputs
    input  seibu_sound_pkg::z80_addr_t      z80_addr,
    input  logic                            z80_rd_n,
    input  logic                            z80_wr_n,
    input  seibu_sound_pkg::z80_data_t      z80_dout,
    input  logic                            m68k_wr,
    input  logic                            m68k_sel,
    input  seibu_sound_pkg::z80_data_t      m68k_din,
    input  seibu_sound_pkg::coin_t          coin,
    input  seibu_sound_pkg::z80_data_t      rom_data,
    input  seibu_sound_pkg::z80_data_t      ram_data,
    input  seibu_sound_pkg::z80_data_t      ym_dout,
    input  seibu_sound_pkg::z80_data_t      oki_dout,

    // dut outputs
    input  seibu_sound_pkg::z80_data_t      z80_din,
    input  logic                            z80_rom_cs,
    input  logic                            bank_rom_cs,
    input  seibu_sound_pkg::bank_rom_addr_t bank_rom_addr,
    input  logic                            z80_ram_cs,
    input  logic                            ym_cs_0,
    input  logic                            ym_cs_1,
    input  logic                            ym_wr,
    input  logic                            oki_wr,
    input  logic                            oki_rd,
    input  seibu_sound_pkg::z80_data_t      reply0,
    input  seibu_sound_pkg::z80_data_t      reply1,
    input  logic                            z80_irq,

    output int                              pass_count,
    output int                              fail_count
);

    // model of the register block
    logic [7:0] ref_latch0;
    logic [7:0] ref_latch1;
    logic [7:0] ref_reply0;
    logic [7:0] ref_reply1;
    logic       ref_pending;
    logic       ref_irq;
    logic       ref_bank;
    logic [1:0] ref_coin;

    function automatic string test_label(input logic [2:0] id);
        case (id)
            3'd0:    return "reset_state";
            3'd1:    return "decode_sweep";
            3'd2:    return "mailbox_to_z80";
            3'd3:    return "reply_to_68k";
            3'd4:    return "bank_switch";
            default: return "coin_read";
        endcase
    endfunction

    task automatic compare_value(input string sig, input logic [15:0] exp,
                                 input logic [15:0] act);
        if (act !== exp) begin
            fail_count = fail_count + 1;
            $display("CHECK FAILED %s %s expected %h actual %h",
                     test_label(test_id), sig, exp, act);
        end else begin
            pass_count = pass_count + 1;
        end
    endtask

    always @(posedge clk) begin : check_edge
        logic       wr;
        logic [7:0] exp_din;
        wr = !z80_wr_n;
        if (rst) begin
            ref_latch0  = 8'h00;
            ref_latch1  = 8'h00;
            ref_reply0  = 8'h00;
            ref_reply1  = 8'h00;
            ref_pending = 1'b0;
            ref_irq     = 1'b0;
            ref_bank    = 1'b0;
            ref_coin    = 2'b00;
            pass_count  = 0;
            fail_count  = 0;
        end else begin
            // read data from the memory map
            if (z80_addr < 16'h2000 || z80_addr >= 16'h8000) begin
                exp_din = rom_data;
            end else if (z80_addr < 16'h2800) begin
                exp_din = ram_data;
            end else begin
                case (z80_addr)
                    16'h4008: exp_din = ym_dout;
                    16'h4010: exp_din = ref_latch0;
                    16'h4011: exp_din = ref_latch1;
                    16'h4012: exp_din = {7'b0, ref_pending};
                    16'h4013: exp_din = {6'b0, ref_coin};
                    16'h6000: exp_din = z80_rd_n ? 8'hff : oki_dout;
                    default:  exp_din = 8'hff;
                endcase
            end

            // outputs against the state before this edge
            compare_value("z80_rom_cs", z80_addr < 16'h2000, z80_rom_cs);
            compare_value("z80_ram_cs", z80_addr >= 16'h2000 && z80_addr < 16'h2800,
                          z80_ram_cs);
            compare_value("bank_rom_cs", z80_addr[15], bank_rom_cs);
            compare_value("ym_cs_0", z80_addr == 16'h4008, ym_cs_0);
            compare_value("ym_cs_1", z80_addr == 16'h4009, ym_cs_1);
            compare_value("ym_wr", (z80_addr[15:1] == 15'h2004) && wr, ym_wr);
            compare_value("oki_rd", z80_addr == 16'h6000 && !z80_rd_n, oki_rd);
            compare_value("oki_wr", z80_addr == 16'h6000 && wr, oki_wr);
            compare_value("z80_din", exp_din, z80_din);
            compare_value("bank_rom_addr", {ref_bank, z80_addr[14:0]}, bank_rom_addr);
            compare_value("reply0", ref_reply0, reply0);
            compare_value("reply1", ref_reply1, reply1);
            compare_value("z80_irq", ref_irq, z80_irq);

            // register updates, a 68k set beats a z80 clear
            if (m68k_wr) begin
                if (m68k_sel) ref_latch1 = m68k_din;
                else ref_latch0 = m68k_din;
                ref_pending = 1'b1;
                ref_irq     = 1'b1;
            end else begin
                if (wr && z80_addr == 16'h4000) ref_pending = 1'b0;
                if (wr && z80_addr == 16'h4001) ref_irq = 1'b0;
            end
            if (wr && z80_addr == 16'h4018) ref_reply0 = z80_dout;
            if (wr && z80_addr == 16'h4019) ref_reply1 = z80_dout;
            if (wr && z80_addr == 16'h4007) ref_bank = z80_dout[0];
            ref_coin = coin;
        end
    end

endmodule

//--- tb_seibu_sound_bus.sv
// ----------------------------------------
// testbench for the seibu sound bus logic
// random z80 and 68k traffic checked by sound_bus_checker
// ----------------------------------------
`timescale 1ns/1ps

module tb_seibu_sound_bus;

    logic                            clk;
    logic                            rst;
    seibu_sound_pkg::z80_addr_t      z80_addr;
    logic                            z80_rd_n;
    logic                            z80_wr_n;
    seibu_sound_pkg::z80_data_t      z80_dout;
    seibu_sound_pkg::z80_data_t      z80_din;
    logic                            m68k_wr;
    logic                            m68k_sel;
    seibu_sound_pkg::z80_data_t      m68k_din;
    seibu_sound_pkg::z80_data_t      reply0;
    seibu_sound_pkg::z80_data_t      reply1;
    logic                            z80_irq;
    seibu_sound_pkg::coin_t          coin;
    seibu_sound_pkg::z80_data_t      rom_data;
    seibu_sound_pkg::z80_data_t      ram_data;
    seibu_sound_pkg::z80_data_t      ym_dout;
    seibu_sound_pkg::z80_data_t      oki_dout;
    logic                            z80_rom_cs;
    logic                            bank_rom_cs;
    seibu_sound_pkg::bank_rom_addr_t bank_rom_addr;
    logic                            z80_ram_cs;
    logic                            ym_cs_0;
    logic                            ym_cs_1;
    logic                            ym_wr;
    logic                            oki_wr;
    logic                            oki_rd;

    // checker link and sequence state
    logic [2:0]  test_id;
    int          pass_count;
    int          fail_count;
    int          timeouts;
    int          fail_base;
    integer      seed;
    logic [31:0] r;
    logic [15:0] addr;
    logic [7:0]  byte_val;
    logic [1:0]  next_coin;
    int          i;
    int          j;

    seibu_sound_bus i_seibu_sound_bus (.*);

    sound_bus_checker i_sound_bus_checker (.*);

    always #4 clk = ~clk;

    // one bus cycle driven on the falling edge with fresh random chip data
    task bus_cycle(input logic [15:0] a, input logic rd_n, input logic wr_n,
                   input logic [7:0] dout, input logic mwr, input logic msel,
                   input logic [7:0] mdin);
        @(negedge clk);
        z80_addr = a;
        z80_rd_n = rd_n;
        z80_wr_n = wr_n;
        z80_dout = dout;
        m68k_wr  = mwr;
        m68k_sel = msel;
        m68k_din = mdin;
        coin     = next_coin;
        rom_data = $random(seed);
        ram_data = $random(seed);
        ym_dout  = $random(seed);
        oki_dout = $random(seed);
    endtask

    // 0x3000 is unmapped so nothing is selected
    task idle_cycle();
        bus_cycle(16'h3000, 1'b1, 1'b1, $random(seed), 1'b0, 1'b0, $random(seed));
    endtask

    task read_cycle(input logic [15:0] a);
        bus_cycle(a, 1'b0, 1'b1, $random(seed), 1'b0, 1'b0, $random(seed));
    endtask

    task write_cycle(input logic [15:0] a, input logic [7:0] d);
        bus_cycle(a, 1'b1, 1'b0, d, 1'b0, 1'b0, $random(seed));
    endtask

    task command_cycle(input logic sel, input logic [7:0] d);
        bus_cycle(16'h3000, 1'b1, 1'b1, $random(seed), 1'b1, sel, d);
    endtask

    task wait_irq_level(input logic level);
        int n;
        n = 0;
        while (z80_irq !== level && n < 10) begin
            idle_cycle();
            n = n + 1;
        end
        if (z80_irq !== level) begin
            $display("timeout: z80_irq never went to %0b", level);
            timeouts = timeouts + 1;
        end
    endtask

    task wait_reply(input logic sel, input logic [7:0] value);
        int n;
        n = 0;
        while ((sel ? reply1 : reply0) !== value && n < 10) begin
            idle_cycle();
            n = n + 1;
        end
        if ((sel ? reply1 : reply0) !== value) begin
            $display("timeout: reply%0d never showed %h", sel, value);
            timeouts = timeouts + 1;
        end
    endtask

    // one extra cycle so the checker has seen the last edge
    task finish_test(input string name);
        idle_cycle();
        $display("test %s done, %0d failures", name, fail_count + timeouts - fail_base);
        fail_base = fail_count + timeouts;
    endtask

    initial begin
        seed      = 32'hdbe7_2f28;
        clk       = 1'b0;
        rst       = 1'b1;
        z80_addr  = 16'h3000;
        z80_rd_n  = 1'b1;
        z80_wr_n  = 1'b1;
        z80_dout  = 8'h00;
        m68k_wr   = 1'b0;
        m68k_sel  = 1'b0;
        m68k_din  = 8'h00;
        coin      = 2'b00;
        next_coin = 2'b00;
        rom_data  = 8'h00;
        ram_data  = 8'h00;
        ym_dout   = 8'h00;
        oki_dout  = 8'h00;
        test_id   = 3'd0;
        timeouts  = 0;
        fail_base = 0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        read_cycle(seibu_sound_pkg::pending_addr);
        finish_test("reset_state");

        // full range, the i/o page, the oki port and the bank boundary
        test_id = 3'd1;
        for (i = 0; i < 300; i = i + 1) begin
            r = $random(seed);
            case (r[1:0])
                2'd0: addr = $random(seed);
                2'd1: addr = 16'h4000 | r[6:2];
                2'd2: addr = seibu_sound_pkg::oki_addr;
                default: addr = 16'h7ffe + r[3:2];
            endcase
            bus_cycle(addr, r[8], r[9], $random(seed), 1'b0, 1'b0, $random(seed));
        end
        finish_test("decode_sweep");

        test_id = 3'd2;
        for (i = 0; i < 4; i = i + 1) begin
            command_cycle(1'b0, $random(seed));
            command_cycle(1'b1, $random(seed));
            r = $random(seed);
            command_cycle(r[0], $random(seed));
            wait_irq_level(1'b1);
            read_cycle(seibu_sound_pkg::latch0_addr);
            read_cycle(seibu_sound_pkg::latch1_addr);
            read_cycle(seibu_sound_pkg::pending_addr);
            if (i[0]) begin
                // irq clear leaves pending alone
                write_cycle(seibu_sound_pkg::irq_clr_addr, $random(seed));
                wait_irq_level(1'b0);
                read_cycle(seibu_sound_pkg::pending_addr);
                write_cycle(seibu_sound_pkg::pending_clr_addr, $random(seed));
                read_cycle(seibu_sound_pkg::pending_addr);
            end else begin
                // pending clear leaves irq alone
                write_cycle(seibu_sound_pkg::pending_clr_addr, $random(seed));
                read_cycle(seibu_sound_pkg::pending_addr);
                write_cycle(seibu_sound_pkg::irq_clr_addr, $random(seed));
                wait_irq_level(1'b0);
            end
        end
        // 68k set on the same edge as each z80 clear
        bus_cycle(seibu_sound_pkg::pending_clr_addr, 1'b1, 1'b0, $random(seed),
                  1'b1, 1'b0, $random(seed));
        read_cycle(seibu_sound_pkg::pending_addr);
        bus_cycle(seibu_sound_pkg::irq_clr_addr, 1'b1, 1'b0, $random(seed),
                  1'b1, 1'b1, $random(seed));
        wait_irq_level(1'b1);
        write_cycle(seibu_sound_pkg::pending_clr_addr, $random(seed));
        write_cycle(seibu_sound_pkg::irq_clr_addr, $random(seed));
        finish_test("mailbox_to_z80");

        test_id = 3'd3;
        for (i = 0; i < 6; i = i + 1) begin
            byte_val = $random(seed);
            addr = i[0] ? seibu_sound_pkg::reply1_addr : seibu_sound_pkg::reply0_addr;
            write_cycle(addr, byte_val);
            wait_reply(i[0], byte_val);
        end
        finish_test("reply_to_68k");

        test_id = 3'd4;
        for (i = 0; i < 6; i = i + 1) begin
            write_cycle(seibu_sound_pkg::bank_addr, $random(seed));
            for (j = 0; j < 3; j = j + 1) begin
                r = $random(seed);
                read_cycle(16'h8000 | r[14:0]);
            end
        end
        finish_test("bank_switch");

        // coin_q lags the switches by one clock
        test_id = 3'd5;
        for (i = 0; i < 10; i = i + 1) begin
            next_coin = $random(seed);
            read_cycle(seibu_sound_pkg::coin_addr);
        end
        finish_test("coin_read");

        $display("checks passed %0d, failed %0d", pass_count, fail_count + timeouts);
        if (fail_count + timeouts == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

//--- files.f
seibu_sound_pkg.sv
z80_cs.sv
sound_regs.sv
z80_rd_mux.sv
seibu_sound_bus.sv
sound_bus_checker.sv
tb_seibu_sound_bus.sv
